// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= dcache_tb
RTL_TOP    ?= dcache_top
FILELIST   ?= dcache.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -E '\.s?v$$' $(FILELIST))
RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dcache.f ====
verilog/dcache_pkg.sv
verilog/dcache_addr_decode.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_result.sv
verilog/dcache_backing_mem.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int BUSY_TIMEOUT = 20;
    localparam int RSP_TIMEOUT  = 20;
    localparam int RAND_OPS     = 400;

    logic        clk;
    logic        arst_n_i;
    dcache_req_t req_i;
    dcache_rsp_t rsp_o;
    logic        busy_o;

    int          err_cnt;
    int          timeout_cnt;
    int          cycle_cnt;
    logic [31:0] lcg_state;

    // reference model of the flat memory and the tags, valid bits and lru bit of each set
    logic [DATA_W-1:0]   ref_mem [2**MEM_AW];
    logic [TAG_W-1:0]    ref_tag [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] ref_valid [NUM_SETS];
    logic [NUM_SETS-1:0] ref_lru;

    // outstanding expectations in request order
    dcache_rsp_t exp_q [$];
    int          exp_lat_q [$];
    int          req_edge_q [$];

    dcache_top uut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .rsp_o    (rsp_o),
        .busy_o   (busy_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // returns the expected response and moves the model on like the cache
    function automatic dcache_rsp_t ref_access(input logic write,
                                               input logic [ADDR_W-1:0] addr,
                                               input logic [DATA_W-1:0] wdata);
        dcache_rsp_t       rsp;
        logic [SET_W-1:0]  set;
        logic [TAG_W-1:0]  tag;
        logic [MEM_AW-1:0] idx;
        logic              hit;
        logic              way;
        set = addr[OFS_W+SET_W-1:OFS_W];
        tag = addr[ADDR_W-1:OFS_W+SET_W];
        idx = addr[MEM_AW+OFS_W-1:OFS_W];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        rsp       = '0;
        rsp.valid = 1'b1;
        rsp.hit   = hit;
        // any hit makes the other way the next victim
        if (hit) begin
            ref_lru[set] = ~way;
        end
        if (write) begin
            ref_mem[idx] = wdata;
        end else begin
            rsp.rdata = ref_mem[idx];
            if (!hit) begin
                if (!ref_valid[set][0]) begin
                    way = 1'b0;
                end else if (!ref_valid[set][1]) begin
                    way = 1'b1;
                end else begin
                    way = ref_lru[set];
                end
                ref_valid[set][way] = 1'b1;
                ref_tag[set][way]   = tag;
                ref_lru[set]        = ~way;
            end
        end
        return rsp;
    endfunction

    task automatic check_rsp(input dcache_rsp_t got, input dcache_rsp_t exp);
        if (got.hit !== exp.hit || got.rdata !== exp.rdata) begin
            err_cnt++;
            $display("FAIL %0t: response hit=%0b rdata=%h, expected hit=%0b rdata=%h",
                     $time, got.hit, got.rdata, exp.hit, exp.rdata);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            err_cnt++;
            $display("FAIL %0t: response latency %0d cycles, expected %0d",
                     $time, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: busy=%b, expected %b", $time, got, exp);
        end
    endtask

    // responses sampled on the falling edge away from register updates
    always @(negedge clk) begin : compare_rsp
        dcache_rsp_t exp;
        int          lat_exp;
        int          req_edge;
        if (arst_n_i === 1'b1 && rsp_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("FAIL %0t: response with no request outstanding", $time);
            end else begin
                exp      = exp_q.pop_front();
                lat_exp  = exp_lat_q.pop_front();
                req_edge = req_edge_q.pop_front();
                check_rsp(rsp_o, exp);
                check_latency(cycle_cnt - req_edge, lat_exp);
            end
        end
    end

    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s] = '0;
        end
        ref_lru = '0;
    endtask

    // one request from falling edge to falling edge
    task automatic do_access(input logic write, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata);
        dcache_rsp_t exp;
        int          wait_cnt;
        if (timeout_cnt != 0) begin
            return;
        end
        wait_cnt = 0;
        while (busy_o !== 1'b0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > BUSY_TIMEOUT) begin
                timeout_cnt++;
                $display("timeout at %0t: cache stayed busy, request not sent", $time);
                return;
            end
        end
        exp = ref_access(write, addr, wdata);
        exp_q.push_back(exp);
        exp_lat_q.push_back((!write && !exp.hit) ? 3 : 1);
        req_edge_q.push_back(cycle_cnt + 1);
        req_i.valid = 1'b1;
        req_i.write = write;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        @(negedge clk);
        req_i.valid = 1'b0;
        wait_cnt = 0;
        while (rsp_o.valid !== 1'b1) begin
            // busy holds from the request edge until the response cycle
            check_busy(busy_o, 1'b1);
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > RSP_TIMEOUT) begin
                timeout_cnt++;
                $display("timeout at %0t: no response for address %h", $time, addr);
                return;
            end
        end
        check_busy(busy_o, 1'b0);
    endtask

    initial begin
        logic [31:0]       r;
        logic [31:0]       d;
        logic [ADDR_W-1:0] addr;
        logic              write;
        err_cnt     = 0;
        timeout_cnt = 0;
        cycle_cnt   = 0;
        lcg_state   = 32'h95e4;
        req_i       = '0;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            ref_mem[i] = '0;
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_tag[s][0] = '0;
            ref_tag[s][1] = '0;
        end
        apply_reset();

        // cold read and a repeat of the same address
        do_access(1'b0, 32'h000, '0);
        do_access(1'b0, 32'h000, '0);
        // set 1 holds two tags and a third evicts the lru one
        do_access(1'b0, 32'h004, '0);
        do_access(1'b0, 32'h024, '0);
        do_access(1'b0, 32'h004, '0);
        do_access(1'b0, 32'h044, '0);
        do_access(1'b0, 32'h004, '0);
        do_access(1'b0, 32'h024, '0);
        // write hit updates the line
        do_access(1'b0, 32'h008, '0);
        do_access(1'b1, 32'h008, 32'hcafe_0008);
        do_access(1'b0, 32'h008, '0);
        // write miss only reaches memory
        do_access(1'b1, 32'h108, 32'h1234_5678);
        do_access(1'b0, 32'h108, '0);
        // lines cached before a reset miss afterwards
        @(negedge clk);
        apply_reset();
        do_access(1'b0, 32'h008, '0);
        do_access(1'b0, 32'h004, '0);

        // random mix over two sets and eight tags
        for (int i = 0; i < RAND_OPS; i++) begin
            r     = lcg_next();
            d     = lcg_next();
            addr  = {22'd0, r[18:16], 4'd0, r[20], 2'b00};
            write = (r[27:25] < 3'd3);
            do_access(write, addr, d);
        end

        @(negedge clk);
        if (timeout_cnt == 0 && exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d responses never arrived", exp_q.size());
        end
        $display("errors: %0d  timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/dcache_addr_decode.sv ====
`timescale 1ns/1ps

module dcache_addr_decode (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  dcache_pkg::dcache_req_t       req_i,
    input  logic                          miss_i,
    output dcache_pkg::dcache_lookup_t    lookup_o,
    output logic                          mem_rd_o,
    output logic                          mem_wr_o,
    output logic [dcache_pkg::MEM_AW-1:0] mem_idx_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata_o,
    output logic                          busy_o
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM_READ,
        ST_MEM_WAIT
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic              accept;
    logic              write_q;
    dcache_addr_u      addr_q;
    logic [DATA_W-1:0] wdata_q;

    // strobes during busy are dropped
    assign accept = req_i.valid && (state_q == ST_IDLE);

    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= req_i.write;
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (accept) state_d = ST_LOOKUP;
            // only read misses go on to memory
            ST_LOOKUP:   state_d = miss_i ? ST_MEM_READ : ST_IDLE;
            ST_MEM_READ: state_d = ST_MEM_WAIT;
            ST_MEM_WAIT: state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign lookup_o = '{
        valid:   (state_q == ST_LOOKUP),
        write:   write_q,
        set:     addr_q.fields.set,
        tag:     addr_q.fields.tag,
        mem_idx: addr_q.word[MEM_AW+OFS_W-1:OFS_W],
        wdata:   wdata_q
    };

    // write-through memory update on the edge that ends lookup
    assign mem_wr_o    = (state_q == ST_LOOKUP) && write_q;
    assign mem_rd_o    = (state_q == ST_MEM_READ);
    assign mem_idx_o   = addr_q.word[MEM_AW+OFS_W-1:OFS_W];
    assign mem_wdata_o = wdata_q;
    assign busy_o      = (state_q != ST_IDLE);

endmodule

// ==== verilog/dcache_backing_mem.sv ====
`timescale 1ns/1ps

module dcache_backing_mem (
    input  logic                          clk,
    input  logic                          rd_i,
    input  logic                          wr_i,
    input  logic [dcache_pkg::MEM_AW-1:0] idx_i,
    input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output logic                          done_o
);
    import dcache_pkg::*;

    logic [DATA_W-1:0] mem_q [2**MEM_AW];
    logic [DATA_W-1:0] rdata_q;
    logic              done_q;

    initial begin
        for (int i = 0; i < 2**MEM_AW; i++) begin
            mem_q[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem_q[idx_i] <= wdata_i;
        end
        if (rd_i) begin
            rdata_q <= mem_q[idx_i];
        end
        // data valid one cycle after the read strobe
        done_q <= rd_i;
    end

    assign rdata_o = rdata_q;
    assign done_o  = done_q;

endmodule

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                                                    clk,
    input  dcache_pkg::dcache_lookup_t                              lookup_i,
    input  dcache_pkg::dcache_fill_t                                fill_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                         wr_way_i,
    output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::DATA_W-1:0] way_data_o
);
    import dcache_pkg::*;

    logic [DATA_W-1:0] data_q [NUM_SETS][NUM_WAYS];

    // refill and write hit never fall in the same cycle
    always_ff @(posedge clk) begin
        if (fill_i.en) begin
            data_q[fill_i.set][fill_i.way] <= fill_i.data;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (wr_way_i[w]) begin
                    data_q[lookup_i.set][w] <= lookup_i.wdata;
                end
            end
        end
    end

    // both ways read out for the current set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_data_o[w] = data_q[lookup_i.set][w];
        end
    end

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int SET_W    = 3;
    localparam int TAG_W    = 27;
    localparam int OFS_W    = 2;
    localparam int NUM_SETS = 8;
    localparam int NUM_WAYS = 2;
    // word index into the 256-word backing memory
    localparam int MEM_AW   = 8;

    // address split into tag, set index and byte offset
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [SET_W-1:0] set;
        logic [OFS_W-1:0] offset;
    } dcache_addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0]   word;
        dcache_addr_fields_t fields;
    } dcache_addr_u;

    typedef struct packed {
        logic              valid;
        logic              write;
        dcache_addr_u      addr;
        logic [DATA_W-1:0] wdata;
    } dcache_req_t;

    typedef struct packed {
        logic              valid;
        logic              hit;
        logic [DATA_W-1:0] rdata;
    } dcache_rsp_t;

    // captured request with valid high only in the lookup cycle
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [SET_W-1:0]  set;
        logic [TAG_W-1:0]  tag;
        logic [MEM_AW-1:0] mem_idx;
        logic [DATA_W-1:0] wdata;
    } dcache_lookup_t;

    typedef struct packed {
        logic              en;
        logic              way;
        logic [SET_W-1:0]  set;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } dcache_fill_t;

endpackage

// ==== verilog/dcache_result.sv ====
`timescale 1ns/1ps

module dcache_result (
    input  logic                                                   clk,
    input  logic                                                   arst_n_i,
    input  dcache_pkg::dcache_lookup_t                             lookup_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                        way_hit_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                        way_valid_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::DATA_W-1:0] way_data_i,
    input  logic [dcache_pkg::DATA_W-1:0]                          mem_rdata_i,
    input  logic                                                   mem_done_i,
    output logic                                                   miss_o,
    output logic [dcache_pkg::NUM_WAYS-1:0]                        wr_way_o,
    output dcache_pkg::dcache_fill_t                               fill_o,
    output dcache_pkg::dcache_rsp_t                                rsp_o
);
    import dcache_pkg::*;

    logic              hit;
    logic              hit_way;
    logic [DATA_W-1:0] hit_data;
    logic              victim;
    logic [NUM_SETS-1:0] lru_q;
    logic              rsp_valid_d;
    logic              rsp_hit_d;
    logic [DATA_W-1:0] rsp_rdata_d;
    logic              rsp_valid_q;
    logic              rsp_hit_q;
    logic [DATA_W-1:0] rsp_rdata_q;

    assign hit      = |way_hit_i;
    assign hit_way  = way_hit_i[1];
    assign hit_data = way_data_i[hit_way];

    // writes are no-allocate so only read misses refill
    assign miss_o   = lookup_i.valid && !lookup_i.write && !hit;
    assign wr_way_o = (lookup_i.valid && lookup_i.write) ? way_hit_i : '0;

    // invalid way 0 first, then invalid way 1, else the lru way
    always_comb begin
        if (!way_valid_i[0]) begin
            victim = 1'b0;
        end else if (!way_valid_i[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[lookup_i.set];
        end
    end

    assign fill_o = '{
        en:   mem_done_i,
        way:  victim,
        set:  lookup_i.set,
        tag:  lookup_i.tag,
        data: mem_rdata_i
    };

    // lru bit names the way to evict next
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lru_q <= '0;
        end else if (fill_o.en) begin
            lru_q[fill_o.set] <= ~fill_o.way;
        end else if (lookup_i.valid && hit) begin
            lru_q[lookup_i.set] <= ~hit_way;
        end
    end

    // zero data for writes and the memory word for read misses
    always_comb begin
        rsp_valid_d = mem_done_i || (lookup_i.valid && !miss_o);
        rsp_hit_d   = lookup_i.valid && hit;
        if (mem_done_i) begin
            rsp_rdata_d = mem_rdata_i;
        end else if (lookup_i.write) begin
            rsp_rdata_d = '0;
        end else begin
            rsp_rdata_d = hit_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rsp_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        rsp_hit_q   <= rsp_hit_d;
        rsp_rdata_q <= rsp_rdata_d;
    end

    assign rsp_o = '{valid: rsp_valid_q, hit: rsp_hit_q, rdata: rsp_rdata_q};

endmodule

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  dcache_pkg::dcache_lookup_t      lookup_i,
    input  dcache_pkg::dcache_fill_t        fill_i,
    output logic [dcache_pkg::NUM_WAYS-1:0] way_hit_o,
    output logic [dcache_pkg::NUM_WAYS-1:0] way_valid_o
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [TAG_W-1:0]                  tag_q [NUM_SETS][NUM_WAYS];

    // a fill marks its way valid
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_i.en) begin
            valid_q[fill_i.set][fill_i.way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i.en) begin
            tag_q[fill_i.set][fill_i.way] <= fill_i.tag;
        end
    end

    // compare both ways of the selected set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_valid_o[w] = valid_q[lookup_i.set][w];
            way_hit_o[w]   = valid_q[lookup_i.set][w] &&
                             (tag_q[lookup_i.set][w] == lookup_i.tag);
        end
    end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  dcache_pkg::dcache_req_t req_i,
    output dcache_pkg::dcache_rsp_t rsp_o,
    output logic                    busy_o
);
    import dcache_pkg::*;

    dcache_lookup_t                    lookup;
    dcache_fill_t                      fill;
    logic                              miss;
    logic [NUM_WAYS-1:0]               way_hit;
    logic [NUM_WAYS-1:0]               way_valid;
    logic [NUM_WAYS-1:0]               wr_way;
    logic [NUM_WAYS-1:0][DATA_W-1:0]   way_data;
    logic                              mem_rd;
    logic                              mem_wr;
    logic [MEM_AW-1:0]                 mem_idx;
    logic [DATA_W-1:0]                 mem_wdata;
    logic [DATA_W-1:0]                 mem_rdata;
    logic                              mem_done;

    dcache_addr_decode u_decode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .miss_i      (miss),
        .lookup_o    (lookup),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_idx_o   (mem_idx),
        .mem_wdata_o (mem_wdata),
        .busy_o      (busy_o)
    );

    dcache_tag_array u_tags (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_i    (lookup),
        .fill_i      (fill),
        .way_hit_o   (way_hit),
        .way_valid_o (way_valid)
    );

    dcache_data_array u_data (
        .clk        (clk),
        .lookup_i   (lookup),
        .fill_i     (fill),
        .wr_way_i   (wr_way),
        .way_data_o (way_data)
    );

    dcache_result u_result (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_i    (lookup),
        .way_hit_i   (way_hit),
        .way_valid_i (way_valid),
        .way_data_i  (way_data),
        .mem_rdata_i (mem_rdata),
        .mem_done_i  (mem_done),
        .miss_o      (miss),
        .wr_way_o    (wr_way),
        .fill_o      (fill),
        .rsp_o       (rsp_o)
    );

    dcache_backing_mem u_mem (
        .clk     (clk),
        .rd_i    (mem_rd),
        .wr_i    (mem_wr),
        .idx_i   (mem_idx),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata),
        .done_o  (mem_done)
    );

endmodule
